/* include/cube_consts.svh */
// ##########################################################################
// Sizing constants for the wireframe cube drawer. Include this header in
// any file that needs coordinate, colour, credit or edge-count widths.
// ##########################################################################

`ifndef CUBE_CONSTS_SVH
`define CUBE_CONSTS_SVH

`define CUBE_CORDW    16    // signed coordinate width

`define CUBE_CIDXW    4     // colour index width

`define CUBE_CREDITS  4     // fb write credits after reset

`define CUBE_EDGES    9     // edges in the cube table

`endif

/* design/cube_pkg.sv */
// ##########################################################################
// Shared types for the cube drawer. Referenced by scoped name only.
// ##########################################################################

`include "cube_consts.svh"

package cube_pkg;

    typedef logic signed [`CUBE_CORDW-1:0] coord_t;   // screen coordinate
    typedef logic [`CUBE_CIDXW-1:0] cidx_t;           // palette index

    // one line command, endpoints inclusive
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } line_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pixel_t;

endpackage

/* design/draw_ifs.sv */
// ##########################################################################
// Handshake bundles between sequencer, line engines and pixel merger.
// line_cmd_if hands a line to an engine, pix_if streams its pixels out.
// ##########################################################################

`timescale 1ns/1ps

interface line_cmd_if;
    logic            start;   // one-cycle pulse, only while busy low
    cube_pkg::line_t line;
    logic            busy;
    logic            done;    // pulse after last pixel accepted

    modport seq (
        output start,
        output line,
        input  busy,
        input  done
    );

    modport eng (
        input  start,
        input  line,
        output busy,
        output done
    );
endinterface

interface pix_if;
    logic             valid;
    cube_pkg::pixel_t pix;    // held until valid && ready
    logic             ready;

    modport src (output valid, output pix, input ready);
    modport dst (input valid, input pix, output ready);
endinterface

/* design/line_sequencer.sv */
// ##########################################################################
// Holds the nine cube edges and hands them to whichever line engine is
// free. Raises done once every edge has finished and the merger is empty.
// ##########################################################################

`timescale 1ns/1ps
`include "cube_consts.svh"

module line_sequencer (
    input  logic clk_100m,
    input  logic rst,
    input  logic start,
    line_cmd_if.seq eng_a,
    line_cmd_if.seq eng_b,
    input  logic merge_idle,
    output logic done
);
    localparam int CNTW = $clog2(`CUBE_EDGES + 1);

    // x0, y0, x1, y1 per edge, front face first
    localparam int EDGE_TAB [`CUBE_EDGES][4] = '{
        '{260, 120, 460, 120}, '{460, 120, 460, 320}, '{460, 320, 260, 320},
        '{260, 320, 260, 120}, '{260, 320, 180, 240}, '{180, 240, 180,  40},
        '{180,  40, 260, 120}, '{180,  40, 380,  40}, '{380,  40, 460, 120}
    };

    typedef enum logic {IDLE, RUN} state_t;

    state_t          state;
    logic [CNTW-1:0] edge_idx;   // next edge to hand out
    logic [CNTW-1:0] done_cnt;   // edges finished so far
    logic            a_free, b_free;

    function automatic cube_pkg::line_t edge_line(input logic [CNTW-1:0] idx);
        cube_pkg::line_t l;
        l.x0   = cube_pkg::coord_t'(EDGE_TAB[idx][0]);
        l.y0   = cube_pkg::coord_t'(EDGE_TAB[idx][1]);
        l.x1   = cube_pkg::coord_t'(EDGE_TAB[idx][2]);
        l.y1   = cube_pkg::coord_t'(EDGE_TAB[idx][3]);
        l.cidx = (idx < 4) ? cube_pkg::cidx_t'(8) : cube_pkg::cidx_t'(4);  // red front
        return l;
    endfunction

    // busy only rises the cycle after start, so mask the start cycle too
    assign a_free = !eng_a.busy && !eng_a.start;
    assign b_free = !eng_b.busy && !eng_b.start;

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state       <= IDLE;
            eng_a.start <= 1'b0;
            eng_b.start <= 1'b0;
            done        <= 1'b0;
            edge_idx    <= '0;
            done_cnt    <= '0;
        end else begin
            eng_a.start <= 1'b0;
            eng_b.start <= 1'b0;
            done        <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    eng_a.start <= 1'b1;          // edge 0 always goes to A
                    eng_a.line  <= edge_line('0);
                    edge_idx    <= CNTW'(1);
                    done_cnt    <= '0;
                    state       <= RUN;
                end
                RUN: begin                        // new start pulses ignored here
                    if (edge_idx < `CUBE_EDGES) begin
                        if (a_free) begin
                            eng_a.start <= 1'b1;
                            eng_a.line  <= edge_line(edge_idx);
                            edge_idx    <= edge_idx + 1'b1;
                        end else if (b_free) begin
                            eng_b.start <= 1'b1;
                            eng_b.line  <= edge_line(edge_idx);
                            edge_idx    <= edge_idx + 1'b1;
                        end
                    end
                    done_cnt <= done_cnt + CNTW'(eng_a.done) + CNTW'(eng_b.done);
                    if (done_cnt == `CUBE_EDGES && merge_idle) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end
endmodule

/* design/draw_line.sv */
// ##########################################################################
// Bresenham line engine. Takes one line per start pulse and emits one
// pixel per accepted cycle, both endpoints included.
// ##########################################################################

`timescale 1ns/1ps
`include "cube_consts.svh"

module draw_line (
    input  logic clk_100m,
    input  logic rst,
    line_cmd_if.eng cmd,
    pix_if.src pix_out
);
    localparam int EW = `CUBE_CORDW + 3;   // room for doubled error term

    logic signed [EW-1:0] ddx, ddy, adx, ady;
    logic signed [EW-1:0] dx_r, dy_r, err_r, e2, err_n;
    cube_pkg::coord_t     cur_x, cur_y, end_x, end_y, sx_r, sy_r, nxt_x, nxt_y;
    cube_pkg::cidx_t      cidx_r;
    logic                 step_x, step_y, accept, last;
    logic                 valid_r, busy_r, done_r;

    // setup values straight from the incoming command
    always_comb begin
        ddx = cmd.line.x1 - cmd.line.x0;
        ddy = cmd.line.y1 - cmd.line.y0;
        adx = (ddx < 0) ? -ddx : ddx;
        ady = (ddy < 0) ? -ddy : ddy;
    end

    always_comb begin
        e2     = err_r <<< 1;
        step_x = (e2 >= dy_r);
        step_y = (e2 <= dx_r);
        nxt_x  = step_x ? cur_x + sx_r : cur_x;
        nxt_y  = step_y ? cur_y + sy_r : cur_y;
        err_n  = err_r + (step_x ? dy_r : '0) + (step_y ? dx_r : '0);
    end

    assign accept = pix_out.valid && pix_out.ready;
    assign last   = (cur_x == end_x) && (cur_y == end_y);

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            valid_r <= 1'b0;
            busy_r  <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (cmd.start) begin
                valid_r <= 1'b1;                  // first pixel next cycle
                busy_r  <= 1'b1;
            end else if (accept && last) begin
                valid_r <= 1'b0;
                busy_r  <= 1'b0;
                done_r  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (cmd.start) begin
            cur_x  <= cmd.line.x0;
            cur_y  <= cmd.line.y0;
            end_x  <= cmd.line.x1;
            end_y  <= cmd.line.y1;
            cidx_r <= cmd.line.cidx;
            dx_r   <= adx;
            dy_r   <= -ady;                       // dy kept negative
            err_r  <= adx - ady;
            sx_r   <= (ddx < 0) ? cube_pkg::coord_t'(-1) : cube_pkg::coord_t'(1);
            sy_r   <= (ddy < 0) ? cube_pkg::coord_t'(-1) : cube_pkg::coord_t'(1);
        end else if (accept && !last) begin       // stall holds everything
            cur_x <= nxt_x;
            cur_y <= nxt_y;
            err_r <= err_n;
        end
    end

    assign pix_out.valid = valid_r;
    assign pix_out.pix   = '{x: cur_x, y: cur_y, cidx: cidx_r};
    assign cmd.busy      = busy_r;
    assign cmd.done      = done_r;
endmodule

/* design/pixel_merger.sv */
// ##########################################################################
// Round-robin merge of two pixel streams onto the framebuffer write port.
// Writes are paced by credits the framebuffer returns on fb_credit.
// ##########################################################################

`timescale 1ns/1ps
`include "cube_consts.svh"

module pixel_merger (
    input  logic clk_100m,
    input  logic rst,
    pix_if.dst pix_a,
    pix_if.dst pix_b,
    input  logic fb_credit,
    output logic fb_we,
    output cube_pkg::coord_t fb_x,
    output cube_pkg::coord_t fb_y,
    output cube_pkg::cidx_t fb_cidx,
    output logic idle
);
    localparam int CRW = $clog2(`CUBE_CREDITS + 1);

    logic [CRW-1:0]   credits;     // spent on fb_we, refilled by fb_credit
    logic             can_take;
    logic             grant_a, grant_b;
    logic             prefer_b;    // round-robin pointer
    cube_pkg::pixel_t sel_pix;

    // the write in the register still owes a credit
    assign can_take = credits > CRW'(fb_we);

    assign grant_a = can_take && pix_a.valid && (!pix_b.valid || !prefer_b);
    assign grant_b = can_take && pix_b.valid && (!pix_a.valid || prefer_b);
    assign pix_a.ready = grant_a;
    assign pix_b.ready = grant_b;
    assign sel_pix = grant_b ? pix_b.pix : pix_a.pix;

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            credits  <= CRW'(`CUBE_CREDITS);
            fb_we    <= 1'b0;
            prefer_b <= 1'b0;
        end else begin
            credits <= credits - CRW'(fb_we) + CRW'(fb_credit);
            fb_we   <= grant_a || grant_b;
            if (grant_a) prefer_b <= 1'b1;
            else if (grant_b) prefer_b <= 1'b0;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (grant_a || grant_b) begin
            fb_x    <= sel_pix.x;
            fb_y    <= sel_pix.y;
            fb_cidx <= sel_pix.cidx;
        end
    end

    assign idle = !fb_we;
endmodule

/* design/cube_drawer.sv */
// ##########################################################################
// Wireframe cube drawer top level. A start pulse draws the cube once as
// framebuffer writes with credit flow control; done marks the end.
// ##########################################################################

`timescale 1ns/1ps

module cube_drawer (
    input  logic             clk_100m,
    input  logic             rst,
    input  logic             start,
    input  logic             fb_credit,   // one per retired write
    output logic             fb_we,
    output cube_pkg::coord_t fb_x,
    output cube_pkg::coord_t fb_y,
    output cube_pkg::cidx_t  fb_cidx,
    output logic             done
);
    logic merge_idle;

    line_cmd_if cmd_a ();
    line_cmd_if cmd_b ();
    pix_if      pix_a ();
    pix_if      pix_b ();

    line_sequencer i_line_sequencer (
        .clk_100m, .rst, .start,
        .eng_a(cmd_a.seq), .eng_b(cmd_b.seq),
        .merge_idle, .done
    );

    // two identical engines working side by side
    draw_line i_line_a (.clk_100m, .rst, .cmd(cmd_a.eng), .pix_out(pix_a.src));
    draw_line i_line_b (.clk_100m, .rst, .cmd(cmd_b.eng), .pix_out(pix_b.src));

    pixel_merger i_pixel_merger (
        .clk_100m, .rst,
        .pix_a(pix_a.dst), .pix_b(pix_b.dst),
        .fb_credit,
        .fb_we, .fb_x, .fb_y, .fb_cidx,
        .idle(merge_idle)
    );
endmodule

/* testbench/tb_clock.sv */
// ##########################################################################
// Clock and reset for the cube drawer testbench. 100 MHz clock, reset
// held high over the first three rising edges.
// ##########################################################################

`timescale 1ns/1ps

module tb_clock (
    output logic clk_100m,
    output logic rst
);
    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;   // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk_100m);
        rst <= 1'b0;
    end
endmodule

/* testbench/cube_drawer_props.sv */
// ##########################################################################
// Credit and done properties for the cube drawer. Bound into the pixel
// merger for the credit rules and into the line sequencer for done.
// ##########################################################################

`timescale 1ns/1ps
`include "cube_consts.svh"

module cube_drawer_props #(
    parameter bit CREDIT_RULES = 1'b1   // credit rules, else the done rule
) (
    input logic                                  clk_100m,
    input logic                                  rst,
    input logic                                  fb_we,
    input logic [$clog2(`CUBE_CREDITS + 1)-1:0]  credits,
    input logic                                  done
);
    if (CREDIT_RULES) begin : g_credit
        // an overrun of outstanding writes wraps the count high
        credits_in_range: assert property (@(posedge clk_100m) disable iff (rst)
            credits <= `CUBE_CREDITS)
            else $error("credit counter out of range: %0d", credits);

        write_needs_credit: assert property (@(posedge clk_100m) disable iff (rst)
            fb_we |-> (credits != '0))
            else $error("fb_we high with no credit held");
    end else begin : g_done
        done_one_cycle: assert property (@(posedge clk_100m) disable iff (rst)
            done |=> !done)
            else $error("done held for more than one cycle");
    end
endmodule

bind pixel_merger cube_drawer_props #(.CREDIT_RULES(1'b1)) i_merger_props (
    .clk_100m, .rst, .fb_we, .credits, .done(1'b0)
);

bind line_sequencer cube_drawer_props #(.CREDIT_RULES(1'b0)) i_sequencer_props (
    .clk_100m, .rst, .fb_we(1'b0), .credits('0), .done
);

/* testbench/tb_cube_drawer.sv */
// ##########################################################################
// Testbench for the cube drawer. Reads test rows from the data file, plays
// the framebuffer by returning credits late, and checks counts and sums.
// ##########################################################################

`timescale 1ns/1ps
`include "cube_consts.svh"

module tb_cube_drawer;
    localparam int WORDS = 5;            // limit, count, x sum, y sum, cidx sum
    localparam int MAX_ROWS = 16;
    localparam int IDLE_CYCLES = 20;
    localparam int RESTART_GAP = 8;
    localparam int SETTLE_CYCLES = 12;

    logic             clk_100m, rst, start, fb_credit, fb_we, done;
    cube_pkg::coord_t fb_x, fb_y;
    cube_pkg::cidx_t  fb_cidx;

    logic [31:0] test_data [0:MAX_ROWS*WORDS-1];
    logic [31:0] lfsr_state = 32'h2801bb1e;
    int          due_q [$];              // cycle at which each credit goes back
    int          cycle_cnt = 0;
    int          timeout_cycles = 0;
    int          last_due = -1;
    int          cur_limit = 0;
    int          in_flight = 0;
    int          writes, writes_at_done, done_pulses, sum_x, sum_y, sum_c;

    tb_clock i_tb_clock (.clk_100m, .rst);

    cube_drawer i_cube_drawer (
        .clk_100m, .rst, .start, .fb_credit,
        .fb_we, .fb_x, .fb_y, .fb_cidx, .done
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois taps
    endfunction

    function automatic int take_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // one clock of watching the write port and returning credits
    task automatic tick();
        int due;
        @(posedge clk_100m);
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("ERROR: drawing did not finish within %0d cycles", timeout_cycles);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
        if (!rst) begin
            if (fb_we) begin
                writes++;
                sum_x += int'(fb_x);
                sum_y += int'(fb_y);
                sum_c += int'(fb_cidx);
                in_flight++;
                check_value("in_flight_within_credits", in_flight <= `CUBE_CREDITS, 1);
                due = cycle_cnt + take_bits(8) % (cur_limit + 1);
                if (due <= last_due) due = last_due + 1;   // one return per cycle
                last_due = due;
                due_q.push_back(due);
            end
            if (done) begin
                done_pulses++;
                writes_at_done = writes;
            end
            if (due_q.size() != 0 && due_q[0] <= cycle_cnt) begin
                void'(due_q.pop_front());
                in_flight--;
                fb_credit <= 1'b1;
            end else begin
                fb_credit <= 1'b0;
            end
        end
    endtask

    task automatic run_row(input int r);
        cur_limit = int'(test_data[r*WORDS]);
        writes = 0;
        writes_at_done = 0;
        done_pulses = 0;
        sum_x = 0;
        sum_y = 0;
        sum_c = 0;
        start <= 1'b1;
        tick();
        start <= 1'b0;
        repeat (RESTART_GAP) tick();
        start <= 1'b1;                   // lands mid-drawing and must be ignored
        tick();
        start <= 1'b0;
        while (done_pulses == 0) tick();
        repeat (SETTLE_CYCLES) tick();
        while (due_q.size() != 0) tick();
        repeat (2) tick();               // last credit absorbed by the merger
        check_value("done_pulses", done_pulses, 1);
        check_value("writes_before_done", writes_at_done, test_data[r*WORDS+1]);
        check_value("fb_we_count", writes, test_data[r*WORDS+1]);
        check_value("sum_fb_x", sum_x, test_data[r*WORDS+2]);
        check_value("sum_fb_y", sum_y, test_data[r*WORDS+3]);
        check_value("sum_fb_cidx", sum_c, test_data[r*WORDS+4]);
        $display("row %0d: delay limit %0d, %0d writes", r, cur_limit, writes);
    endtask

    initial begin
        int rows;
        int r;
        start = 1'b0;
        fb_credit = 1'b0;
        $readmemh("testbench/cube_input.txt", test_data);
        rows = 0;
        timeout_cycles = 200;
        while (rows < MAX_ROWS && !$isunknown(test_data[rows*WORDS+1])
               && test_data[rows*WORDS+1] != 0) begin
            timeout_cycles += int'(test_data[rows*WORDS+1])
                              * (int'(test_data[rows*WORDS]) + 2);
            rows++;
        end
        do tick(); while (rst);
        repeat (IDLE_CYCLES) begin       // nothing moves before a start
            tick();
            check_value("fb_we", fb_we, 1'b0);
            check_value("done", done, 1'b0);
        end
        for (r = 0; r < rows; r++) run_row(r);
        if (rows == 0) begin
            $display("ERROR: no test rows found in testbench/cube_input.txt");
            $display("FAIL: see errors above");
            $fatal(1, "no stimulus");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end
endmodule

/* testbench/cube_input.txt */
// cube drawer test rows, one row per test, all values in hex
// columns: credit-return delay limit, expected fb_we count,
//          sum of fb_x, sum of fb_y, sum of fb_cidx over all writes
// every row draws the same cube: 6 edges of 201 pixels, 3 of 81
// 1449 writes, x sum 451560, y sum 248700, cidx sum 9012
// rows run back to back without a reset in between
00000000 000005A9 0006E3E8 0003CB7C 00002334
00000001 000005A9 0006E3E8 0003CB7C 00002334
00000003 000005A9 0006E3E8 0003CB7C 00002334
00000006 000005A9 0006E3E8 0003CB7C 00002334
0000000A 000005A9 0006E3E8 0003CB7C 00002334
00000012 000005A9 0006E3E8 0003CB7C 00002334
0000001E 000005A9 0006E3E8 0003CB7C 00002334
0000003C 000005A9 0006E3E8 0003CB7C 00002334

/* verilog.f */
+incdir+include
design/cube_pkg.sv
design/draw_ifs.sv
design/line_sequencer.sv
design/draw_line.sv
design/pixel_merger.sv
design/cube_drawer.sv
testbench/tb_clock.sv
testbench/cube_drawer_props.sv
testbench/tb_cube_drawer.sv

/* Makefile */
# Verilator flow for the cube drawer: lint, build, simulate, clean.
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_cube_drawer
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= PASS: all tests
JOBS       ?= 4
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
